// ==== cache_geom_pkg.sv ====
package cache_geom_pkg;

	// ------------------------------------------------------------------------
	// Address layout
	// ------------------------------------------------------------------------
	// Word address, bit 27 selects the uncached I/O window
	//   [27]    I/O window
	//   [26:2]  line address, stored whole as the tag
	//   [1:0]   word in line
	localparam int ADDR_W      = 28;
	localparam int WORD_W      = 32;
	localparam int LINE_WORDS  = 4;
	localparam int OFFSET_W    = 2;
	localparam int IO_BIT      = 27;
	localparam int LINE_ADDR_W = IO_BIT - OFFSET_W; // 25 bits

	// ------------------------------------------------------------------------
	// Data types
	// ------------------------------------------------------------------------
	typedef logic [WORD_W-1:0] word_t;

	// Word 0 sits in the low 32 bits
	typedef word_t [LINE_WORDS-1:0] line_t;

	// Full line address, independent of the set count
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

endpackage

// ==== cache_bus_pkg.sv ====
package cache_bus_pkg;

	import cache_geom_pkg::*;

	// CPU side request, flush ignores addr and wdata
	typedef struct packed {
		logic              write;
		logic              flush;
		logic [ADDR_W-1:0] addr;
		word_t             wdata;
	} cpu_req_t;

	typedef struct packed {
		word_t rdata;
	} cpu_resp_t;

	// Line-wide memory port
	typedef struct packed {
		logic       write;
		line_addr_t line_addr;
		line_t      wdata;    // Only meaningful on a write-back
	} mem_req_t;

	typedef struct packed {
		line_t rdata;
	} mem_resp_t;

	// Uncached I/O window
	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] addr;
		word_t             wdata;
	} io_req_t;

	// Lookup result of one way for the indexed set
	typedef struct packed {
		logic       hit;
		logic       valid;
		logic       dirty;
		line_addr_t line_addr;
		line_t      line;
	} way_view_t;

endpackage

// ==== cache_req_router.sv ====
module cache_req_router
	import cache_geom_pkg::*, cache_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cpu_req_valid,
	input  cpu_req_t  cpu_req,
	output logic      ctrl_req_valid,
	output cpu_req_t  ctrl_req,
	output logic      io_req_valid,
	output io_req_t   io_req,
	input  logic      io_resp_valid,
	input  word_t     io_rdata,
	output logic      io_resp_valid_out,
	output cpu_resp_t io_resp
);

	cpu_req_t req_q;
	logic     is_io;

	// The one place the window is decided; flush always goes to the cache
	assign is_io = cpu_req.addr[IO_BIT] && !cpu_req.flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_req_valid    <= 1'b0;
			io_req_valid      <= 1'b0;
			io_resp_valid_out <= 1'b0;
		end else begin
			ctrl_req_valid    <= cpu_req_valid && !is_io;
			io_req_valid      <= cpu_req_valid && is_io;
			io_resp_valid_out <= io_resp_valid; // I/O answer one cycle later
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_req_valid)
			req_q <= cpu_req;
		if (io_resp_valid)
			io_resp.rdata <= io_rdata;
	end

	assign ctrl_req = req_q;

	always_comb begin
		io_req.write = req_q.write;
		io_req.addr  = req_q.addr;
		io_req.wdata = req_q.wdata;
	end

endmodule

// ==== cache_way.sv ====
module cache_way
	import cache_geom_pkg::*, cache_bus_pkg::*;
#(
	parameter  int NUM_SETS = 16,
	localparam int SET_W    = $clog2(NUM_SETS)
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [SET_W-1:0] set_idx,
	input  line_addr_t       lookup_addr,
	input  logic             wr_en,
	input  line_t            wr_line,
	input  logic             wr_dirty,
	input  line_addr_t       wr_line_addr,
	input  logic             clr_valid_dirty_only,
	output way_view_t        view
);

	line_t      data_mem [NUM_SETS];
	line_addr_t tag_mem  [NUM_SETS];

	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;

	// ------------------------------------------------------------------------
	// State bits
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			if (clr_valid_dirty_only) begin
				dirty_q[set_idx] <= 1'b0; // Flush keeps the line valid
			end else begin
				valid_q[set_idx] <= 1'b1;
				dirty_q[set_idx] <= wr_dirty;
			end
		end
	end

	// Line data and tag, untouched by a dirty clear
	always_ff @(posedge clk) begin
		if (wr_en && !clr_valid_dirty_only) begin
			data_mem[set_idx] <= wr_line;
			tag_mem[set_idx]  <= wr_line_addr;
		end
	end

	// ------------------------------------------------------------------------
	// Combinational read of the indexed set
	// ------------------------------------------------------------------------
	always_comb begin
		view.valid     = valid_q[set_idx];
		view.dirty     = dirty_q[set_idx];
		view.line_addr = tag_mem[set_idx];
		view.line      = data_mem[set_idx];
		view.hit       = valid_q[set_idx] && (tag_mem[set_idx] == lookup_addr);
	end

endmodule

// ==== cache_way_select.sv ====
module cache_way_select
	import cache_geom_pkg::*, cache_bus_pkg::*;
#(
	parameter  int NUM_WAYS = 2,
	localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
	input  way_view_t [NUM_WAYS-1:0] views,
	input  logic [OFFSET_W-1:0]      word_off,
	input  logic [WAY_W-1:0]         pick_way,
	output logic                     any_hit,
	output logic [WAY_W-1:0]         hit_way,
	output word_t                    hit_word,
	output line_t                    hit_line,
	output way_view_t                pick_view
);

	// Hit reduction, at most one way matches a given tag
	always_comb begin
		any_hit = 1'b0;
		hit_way = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (views[i].hit) begin
				any_hit = 1'b1;
				hit_way = WAY_W'(i);
			end
		end
	end

	assign hit_line = views[hit_way].line;
	assign hit_word = hit_line[word_off];

	// Victim on a miss, walk entry during a flush
	assign pick_view = views[pick_way];

endmodule

// ==== cache_ctrl.sv ====
module cache_ctrl
	import cache_geom_pkg::*, cache_bus_pkg::*;
#(
	parameter  int NUM_WAYS = 2,
	parameter  int NUM_SETS = 16,
	localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
	localparam int SET_W    = $clog2(NUM_SETS)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	input  cpu_req_t            req,
	output logic                resp_valid,
	output cpu_resp_t           resp,
	output logic [SET_W-1:0]    set_idx,
	output line_addr_t          lookup_addr,
	output logic [NUM_WAYS-1:0] way_wr_en,
	output line_t               wr_line,
	output logic                wr_dirty,
	output line_addr_t          wr_line_addr,
	output logic                clr_dirty,
	output logic [OFFSET_W-1:0] word_off,
	output logic [WAY_W-1:0]    pick_way,
	input  logic                any_hit,
	input  logic [WAY_W-1:0]    hit_way,
	input  word_t               hit_word,
	input  line_t               hit_line,
	input  way_view_t           pick_view,
	output logic                mem_req_valid,
	output mem_req_t            mem_req,
	input  logic                mem_resp_valid,
	input  mem_resp_t           mem_resp
);

	typedef enum logic [2:0] {IDLE, LOOKUP, WRITE_BACK, ALLOCATE, FLUSH_WALK} state_t;
	typedef logic [NUM_WAYS-1:0][WAY_W-1:0] order_t; // Entry 0 is the LRU way

	state_t            state_q;
	cpu_req_t          req_q;
	order_t            lru_q [NUM_SETS];
	line_addr_t        req_line;
	logic [SET_W-1:0]  req_set;
	logic [WAY_W-1:0]  lru_way, victim_q, walk_way_q;
	logic [SET_W-1:0]  walk_set_q;
	logic              walk_done_q, flush_mode_q;
	logic              wb_needed, issue_wb, issue_fill, resp_fire;
	line_t             merged_line;

	// Move the touched way to the MRU end, the rest keep their order
	function automatic order_t touch(input order_t ord, input logic [WAY_W-1:0] way);
		order_t res;
		logic   seen;
		seen = 1'b0;
		for (int k = 0; k < NUM_WAYS - 1; k++) begin
			seen   = seen || (ord[k] == way);
			res[k] = seen ? ord[k+1] : ord[k];
		end
		res[NUM_WAYS-1] = way;
		return res;
	endfunction

	assign req_line  = req_q.addr[IO_BIT-1:OFFSET_W];
	assign req_set   = req_line[SET_W-1:0];
	assign lru_way   = lru_q[req_set][0];
	assign wb_needed = pick_view.valid && pick_view.dirty;

	assign issue_wb   = wb_needed && ((state_q == LOOKUP && !any_hit) ||
		(state_q == FLUSH_WALK && !walk_done_q));
	assign issue_fill = (state_q == LOOKUP && !any_hit && !wb_needed) ||
		(state_q == WRITE_BACK && mem_resp_valid && !flush_mode_q);
	assign resp_fire  = (state_q == LOOKUP && any_hit) ||
		(state_q == FLUSH_WALK && walk_done_q);

	// ------------------------------------------------------------------------
	// Way array control
	// ------------------------------------------------------------------------
	always_comb begin
		set_idx     = (state_q == FLUSH_WALK) ? walk_set_q : req_set;
		lookup_addr = req_line;
		word_off    = req_q.addr[OFFSET_W-1:0];
		pick_way    = victim_q;
		if (state_q == LOOKUP)
			pick_way = lru_way;
		else if (state_q == FLUSH_WALK)
			pick_way = walk_way_q;
		merged_line           = hit_line;
		merged_line[word_off] = req_q.wdata;
		way_wr_en    = '0;
		wr_line      = merged_line; // Write hit by default
		wr_dirty     = 1'b1;
		wr_line_addr = req_line;
		clr_dirty    = 1'b0;
		case (state_q)
			LOOKUP: if (any_hit && req_q.write) way_wr_en[hit_way] = 1'b1;
			ALLOCATE: if (mem_resp_valid) begin
				way_wr_en[victim_q] = 1'b1;
				wr_line             = mem_resp.rdata; // Installed clean
				wr_dirty            = 1'b0;
			end
			FLUSH_WALK: if (issue_wb) begin
				way_wr_en[walk_way_q] = 1'b1;
				clr_dirty             = 1'b1;
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------------------
	// FSM and LRU
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q       <= IDLE;
			resp_valid    <= 1'b0;
			mem_req_valid <= 1'b0;
			victim_q      <= '0;
			walk_set_q    <= '0;
			walk_way_q    <= '0;
			walk_done_q   <= 1'b0;
			flush_mode_q  <= 1'b0;
			for (int s = 0; s < NUM_SETS; s++)
				for (int w = 0; w < NUM_WAYS; w++)
					lru_q[s][w] <= WAY_W'(w);
		end else begin
			resp_valid    <= resp_fire;
			mem_req_valid <= issue_wb || issue_fill;
			case (state_q)
				IDLE: if (req_valid) begin
					flush_mode_q <= req.flush;
					walk_set_q   <= '0;
					walk_way_q   <= '0;
					walk_done_q  <= 1'b0;
					state_q      <= req.flush ? FLUSH_WALK : LOOKUP;
				end
				LOOKUP: if (any_hit) begin
					lru_q[req_set] <= touch(lru_q[req_set], hit_way);
					state_q        <= IDLE;
				end else begin
					victim_q <= lru_way;
					state_q  <= wb_needed ? WRITE_BACK : ALLOCATE;
				end
				WRITE_BACK: if (mem_resp_valid) state_q <= flush_mode_q ? FLUSH_WALK : ALLOCATE;
				ALLOCATE: if (mem_resp_valid) state_q <= LOOKUP; // Retry now hits
				FLUSH_WALK: if (walk_done_q) begin
					state_q <= IDLE;
				end else begin
					if (issue_wb)
						state_q <= WRITE_BACK;
					if (walk_way_q == WAY_W'(NUM_WAYS - 1)) begin
						walk_way_q <= '0;
						if (walk_set_q == SET_W'(NUM_SETS - 1))
							walk_done_q <= 1'b1;
						else
							walk_set_q <= walk_set_q + 1'b1;
					end else begin
						walk_way_q <= walk_way_q + 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (state_q == IDLE && req_valid)
			req_q <= req;
		if (issue_wb) begin
			mem_req.write     <= 1'b1;
			mem_req.line_addr <= pick_view.line_addr;
			mem_req.wdata     <= pick_view.line;
		end else if (issue_fill) begin
			mem_req.write     <= 1'b0;
			mem_req.line_addr <= req_line;
			mem_req.wdata     <= '0;
		end
		if (resp_fire)
			resp.rdata <= (state_q == LOOKUP && !req_q.write) ? hit_word : '0;
	end

endmodule

// ==== cache_top.sv ====
module cache_top
	import cache_geom_pkg::*, cache_bus_pkg::*;
#(
	parameter  int NUM_WAYS = 2,
	parameter  int NUM_SETS = 16,
	localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
	localparam int SET_W    = $clog2(NUM_SETS)
) (
	input  logic      clk,
	input  logic      rst_n,
	// CPU port
	input  logic      cpu_req_valid,
	input  cpu_req_t  cpu_req,
	output logic      cpu_resp_valid,
	output cpu_resp_t cpu_resp,
	// Memory port
	output logic      mem_req_valid,
	output mem_req_t  mem_req,
	input  logic      mem_resp_valid,
	input  mem_resp_t mem_resp,
	// I/O port
	output logic      io_req_valid,
	output io_req_t   io_req,
	input  logic      io_resp_valid,
	input  word_t     io_rdata
);

	logic                ctrl_req_valid, ctrl_resp_valid, io_resp_valid_r;
	cpu_req_t            ctrl_req;
	cpu_resp_t           ctrl_resp, io_resp;
	logic [SET_W-1:0]    set_idx;
	line_addr_t          lookup_addr, wr_line_addr;
	logic [NUM_WAYS-1:0] way_wr_en;
	line_t               wr_line, hit_line;
	logic                wr_dirty, clr_dirty, any_hit;
	logic [OFFSET_W-1:0] word_off;
	logic [WAY_W-1:0]    pick_way, hit_way;
	word_t               hit_word;
	way_view_t           pick_view;
	way_view_t [NUM_WAYS-1:0] views;

	cache_req_router u_router (
		.clk, .rst_n, .cpu_req_valid, .cpu_req, .ctrl_req_valid, .ctrl_req,
		.io_req_valid, .io_req, .io_resp_valid, .io_rdata,
		.io_resp_valid_out(io_resp_valid_r), .io_resp
	);

	cache_ctrl #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_ctrl (
		.clk, .rst_n, .req_valid(ctrl_req_valid), .req(ctrl_req),
		.resp_valid(ctrl_resp_valid), .resp(ctrl_resp),
		.set_idx, .lookup_addr, .way_wr_en, .wr_line, .wr_dirty, .wr_line_addr, .clr_dirty,
		.word_off, .pick_way, .any_hit, .hit_way, .hit_word, .hit_line, .pick_view,
		.mem_req_valid, .mem_req, .mem_resp_valid, .mem_resp
	);

	for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way
		cache_way #(.NUM_SETS(NUM_SETS)) u_way (
			.clk, .rst_n, .set_idx, .lookup_addr, .wr_en(way_wr_en[i]), .wr_line, .wr_dirty,
			.wr_line_addr, .clr_valid_dirty_only(clr_dirty), .view(views[i])
		);
	end

	cache_way_select #(.NUM_WAYS(NUM_WAYS)) u_sel (
		.views, .word_off, .pick_way, .any_hit, .hit_way, .hit_word, .hit_line, .pick_view
	);

	// One request outstanding, so the two strobes never collide
	assign cpu_resp_valid = io_resp_valid_r || ctrl_resp_valid;
	assign cpu_resp       = io_resp_valid_r ? io_resp : ctrl_resp;

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model
	import cache_geom_pkg::*, cache_bus_pkg::*;
(
	input  logic      clk,
	input  logic      mem_req_valid,
	input  mem_req_t  mem_req,
	output logic      mem_resp_valid,
	output mem_resp_t mem_resp,
	input  logic      io_req_valid,
	input  io_req_t   io_req,
	output logic      io_resp_valid,
	output word_t     io_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	line_t       lines [line_addr_t]; // Only lines that were written back
	mem_req_t    mem_log [$];         // Every memory request, in order
	io_req_t     io_log [$];
	mem_req_t    mem_pend;
	io_req_t     io_pend;
	int          mem_cnt, io_cnt;
	logic [31:0] rng;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Unwritten word w holds {4'hA, w} ^ 32'h5A5A_0000
	function automatic line_t read_line(input line_addr_t la);
		line_t fresh;
		for (int k = 0; k < LINE_WORDS; k++)
			fresh[k] = {4'hA, 1'b0, la, OFFSET_W'(k)} ^ 32'h5A5A_0000;
		return lines.exists(la) ? lines[la] : fresh;
	endfunction

	initial begin
		rng            = 32'd62257;
		mem_resp_valid = 1'b0;
		mem_resp       = '0;
		io_resp_valid  = 1'b0;
		io_rdata       = '0;
		mem_cnt        = 0;
		io_cnt         = 0;
	end

	// Answers are driven on the falling edge, 1 to 4 cycles after the request
	always @(negedge clk) begin
		mem_resp_valid = 1'b0;
		io_resp_valid  = 1'b0;
		if (mem_cnt > 0) begin
			mem_cnt--;
			if (mem_cnt == 0) begin
				mem_resp.rdata = mem_pend.write ? '0 : read_line(mem_pend.line_addr);
				mem_resp_valid = 1'b1;
			end
		end
		if (io_cnt > 0) begin
			io_cnt--;
			if (io_cnt == 0) begin
				io_rdata      = io_pend.write ? '0 : {4'h0, io_pend.addr} ^ 32'h1234_5678;
				io_resp_valid = 1'b1;
			end
		end
		if (mem_req_valid) begin
			mem_pend = mem_req;
			mem_log.push_back(mem_req);
			if (mem_req.write)
				lines[mem_req.line_addr] = mem_req.wdata;
			rng     = xorshift(rng);
			mem_cnt = int'(rng[1:0]) + 1;
		end
		if (io_req_valid) begin
			io_pend = io_req;
			io_log.push_back(io_req);
			rng    = xorshift(rng);
			io_cnt = int'(rng[1:0]) + 1;
		end
	end

endmodule

// ==== cache_chk.sv ====
module cache_chk #(
	parameter int NUM_WAYS = 2
) (
	input logic                clk,
	input logic                rst_n,
	input logic [NUM_WAYS-1:0] way_wr_en,
	input logic                mem_req_valid,
	input logic                mem_resp_valid,
	input logic                resp_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	logic mem_busy_q; // Memory transaction in flight
	int   fail_count = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_busy_q <= 1'b0;
		else if (mem_req_valid)
			mem_busy_q <= 1'b1;
		else if (mem_resp_valid)
			mem_busy_q <= 1'b0;
	end

	a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_wr_en))
		else begin
			$error("way_wr_en has more than one way set: %b", way_wr_en);
			fail_count++;
		end

	a_mem_single: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |-> !mem_busy_q)
		else begin
			$error("mem_req_valid while a memory transaction is outstanding");
			fail_count++;
		end

	a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |=> !resp_valid)
		else begin
			$error("resp_valid high for two cycles in a row");
			fail_count++;
		end

endmodule

bind cache_ctrl cache_chk #(.NUM_WAYS(NUM_WAYS)) u_chk (
	.clk(clk), .rst_n(rst_n), .way_wr_en(way_wr_en), .mem_req_valid(mem_req_valid),
	.mem_resp_valid(mem_resp_valid), .resp_valid(resp_valid)
);

// ==== tb_cache_top.sv ====
module tb_cache_top
	import cache_geom_pkg::*, cache_bus_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_PATS  = 64;
	localparam int REQ_LIMIT = 400; // Cycles one request may take

	logic      clk, rst_n;
	logic      cpu_req_valid, cpu_resp_valid;
	cpu_req_t  cpu_req;
	cpu_resp_t cpu_resp;
	logic      mem_req_valid, mem_resp_valid, io_req_valid, io_resp_valid;
	mem_req_t  mem_req;
	mem_resp_t mem_resp;
	io_req_t   io_req;
	word_t     io_rdata;

	logic [31:0] pat_mem [4*MAX_PATS];
	word_t       shadow [logic [ADDR_W-1:0]];
	bit          dirty_lines [line_addr_t]; // Lines written since their last write-back
	int          num_pats, errors, test_errs, tests_failed;
	bit          loaded;

	cache_top #(.NUM_WAYS(2), .NUM_SETS(16)) u_dut (.*);

	tb_mem_model u_mem (.*);

	always #50 clk = ~clk;

	function automatic word_t shadow_word(input logic [ADDR_W-1:0] w);
		return shadow.exists(w) ? shadow[w] : ({4'hA, w} ^ 32'h5A5A_0000);
	endfunction

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error %s: got %h, expected %h", name, got, exp);
		test_errs++;
	endtask

	// ------------------------------------------------------------------------
	// Op word of a pattern holds the op in [3:0], fills in [7:4] and write-backs in [11:8]
	// ------------------------------------------------------------------------
	task automatic run_test(input int idx);
		logic [31:0]       opw;
		logic [ADDR_W-1:0] addr;
		word_t             wdata, exp;
		mem_req_t          ev;
		io_req_t           io_ev;
		int                cycles, fills, wbs;
		bit                is_io, seen_fill;
		opw       = pat_mem[4*idx];
		addr      = pat_mem[4*idx+1][ADDR_W-1:0];
		wdata     = pat_mem[4*idx+2];
		exp       = pat_mem[4*idx+3];
		is_io     = addr[IO_BIT] && opw[3:0] != 4'd2;
		test_errs = 0;
		fills     = 0;
		wbs       = 0;
		seen_fill = 1'b0;
		cpu_req.write = (opw[3:0] == 4'd1);
		cpu_req.flush = (opw[3:0] == 4'd2);
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cpu_req_valid = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cpu_req_valid = 1'b0;
			cycles++;
		end while (!cpu_resp_valid && cycles < REQ_LIMIT);
		if (!cpu_resp_valid) begin
			$display("Test %0d got no response within %0d cycles", idx, REQ_LIMIT);
			test_errs++;
		end else if (cpu_resp.rdata !== exp)
			report_value("cpu_resp.rdata", cpu_resp.rdata, exp);
		while (u_mem.mem_log.size() > 0) begin
			ev = u_mem.mem_log.pop_front();
			if (ev.write) begin
				wbs++;
				if (seen_fill) begin
					$display("Write-back of line %h came after the fill", ev.line_addr);
					test_errs++;
				end
				if (!dirty_lines.exists(ev.line_addr)) begin
					$display("Write-back of line %h, which holds no new data", ev.line_addr);
					test_errs++;
				end
				dirty_lines.delete(ev.line_addr);
				for (int k = 0; k < LINE_WORDS; k++)
					if (ev.wdata[k] !== shadow_word({1'b0, ev.line_addr, OFFSET_W'(k)}))
						report_value("mem_req.wdata", ev.wdata[k],
							shadow_word({1'b0, ev.line_addr, OFFSET_W'(k)}));
			end else begin
				fills++;
				seen_fill = 1'b1;
				if (ev.line_addr !== addr[IO_BIT-1:OFFSET_W])
					report_value("mem_req.line_addr", ev.line_addr, addr[IO_BIT-1:OFFSET_W]);
			end
		end
		if (fills != int'(opw[7:4]))
			report_value("mem_req_valid fills", fills, opw[7:4]);
		if (wbs != int'(opw[11:8]))
			report_value("mem_req_valid write-backs", wbs, opw[11:8]);
		if (!is_io && opw[3:0] != 4'd2 && fills == 0 && wbs == 0 && cycles != 3)
			report_value("cpu_resp_valid latency", cycles, 3);
		if (is_io && u_mem.io_log.size() != 1) begin
			$display("Test %0d expected one I/O request, saw %0d", idx, u_mem.io_log.size());
			test_errs++;
		end else if (is_io) begin
			io_ev = u_mem.io_log.pop_front();
			if (io_ev.write !== (opw[3:0] == 4'd1))
				report_value("io_req.write", io_ev.write, opw[3:0] == 4'd1);
			if (io_ev.addr !== addr)
				report_value("io_req.addr", io_ev.addr, addr);
			if (io_ev.wdata !== wdata)
				report_value("io_req.wdata", io_ev.wdata, wdata);
		end else if (u_mem.io_log.size() != 0) begin
			$display("Test %0d sent a request to the I/O port", idx);
			test_errs++;
		end
		u_mem.io_log.delete();
		if (!is_io && opw[3:0] == 4'd1) begin
			shadow[addr] = wdata;
			dirty_lines[addr[IO_BIT-1:OFFSET_W]] = 1'b1;
		end
		if (opw[3:0] == 4'd2 && dirty_lines.num() != 0) begin
			$display("Flush finished with %0d dirty lines not written back", dirty_lines.num());
			test_errs++;
		end
		$display("Test %0d op %0h addr %h: %s", idx, opw[3:0], addr,
			(test_errs == 0) ? "passed" : "failed");
		errors += test_errs;
		if (test_errs != 0)
			tests_failed++;
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req       = '0;
		errors        = 0;
		tests_failed  = 0;
		num_pats      = 0;
		loaded        = 1'b0;
		for (int i = 0; i < 4*MAX_PATS; i++)
			pat_mem[i] = '1; // Op nibble F ends the list
		$readmemh("cache_patterns.txt", pat_mem);
		while (num_pats < MAX_PATS && pat_mem[4*num_pats][3:0] <= 4'd2)
			num_pats++;
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (num_pats == 0) begin
			$display("No patterns found in cache_patterns.txt");
			errors++;
		end
		for (int i = 0; i < num_pats; i++) begin
			@(negedge clk);
			run_test(i);
		end
		repeat (4) @(negedge clk);
		if (u_dut.u_ctrl.u_chk.fail_count != 0) begin
			$display("%0d controller protocol assertions failed",
				u_dut.u_ctrl.u_chk.fail_count);
			errors += u_dut.u_ctrl.u_chk.fail_count;
		end
		$display("%0d tests, %0d failed, %0d errors", num_pats, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial begin
		wait (loaded);
		repeat (num_pats * 40 + 200) @(posedge clk);
		$display("Watchdog expired before all tests finished");
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== cache_patterns.txt ====
// op addr wdata expected_rdata, all hex
// op: [3:0] 0 read 1 write 2 flush, [7:4] fills expected, [11:8] write-backs expected
0010 0000010 00000000 FA5A0010
0001 0000011 11112222 00000000
0000 0000011 00000000 11112222
0010 0000000 00000000 FA5A0000
0010 0000041 00000000 FA5A0041
0000 0000002 00000000 FA5A0002
0010 0000083 00000000 FA5A0083
0000 0000001 00000000 FA5A0001
0010 0000040 00000000 FA5A0040
0011 0000009 DEADBEEF 00000000
0010 0000049 00000000 FA5A0049
0110 000008A 00000000 FA5A008A
0010 0000009 00000000 DEADBEEF
0011 0000020 0A0B0C0D 00000000
0001 0000021 55AA55AA 00000000
0001 0000003 01234567 00000000
0302 0000000 00000000 00000000
0002 0000000 00000000 00000000
0000 0000003 00000000 01234567
0000 8000100 00000000 1A345778
0001 8000104 CAFEF00D 00000000
0000 8000010 00000000 1A345668

// ==== cache.f ====
cache_geom_pkg.sv
cache_bus_pkg.sv
cache_req_router.sv
cache_way.sv
cache_way_select.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
cache_chk.sv
tb_cache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_top -f cache.f -o sim_cache \
	&& { ./obj_dir/sim_cache > sim.log 2>&1 || true; } \
	&& grep -qx "Done: no errors" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
